//--- files.f
hw/opl3_pkg.sv
hw/opl3_osc_regs.sv
hw/sample_strobe.sv
hw/sine_lut.sv
hw/nco.sv
hw/opl3_osc_top.sv
verification/tb_clk_gen.sv
verification/opl3_osc_tb.sv

//--- hw/nco.sv
// Numerically controlled oscillator.
// Phase accumulator, sine lookup, OPL3 waveform shaping and the output register.
`timescale 1ns/1ps

module nco
    import opl3_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           en,
    input  logic [PHASE_ACC_WIDTH-1:0]     phase_inc,
    input  waveform_t                      ws,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic signed [OUTPUT_WIDTH-1:0] out,
    output logic                           stall
);

    localparam logic signed [OUTPUT_WIDTH-1:0] FULL_POS = 2 ** (OUTPUT_WIDTH - 1) - 1;
    localparam logic signed [OUTPUT_WIDTH-1:0] FULL_NEG = -(2 ** (OUTPUT_WIDTH - 1));

    logic [PHASE_ACC_WIDTH-1:0]     phase_acc;
    logic [PHASE_ACC_WIDTH-1:0]     step;
    logic signed [OUTPUT_WIDTH-1:0] lut_out;
    logic signed [OUTPUT_WIDTH-1:0] abs_sine;
    logic signed [OUTPUT_WIDTH-1:0] alt_sine;
    logic signed [OUTPUT_WIDTH-1:0] shaped;
    logic                           en_q1;  // Accumulator has the new phase.
    logic                           en_q2;  // Table output has the new sample.
    logic                           sign_q;
    logic                           sign_wrap;
    logic                           is_odd_q;
    logic                           odd_period;

    // Alternating shapes run at twice the pitch.
    assign step = (ws == ws_alt_sine || ws == ws_alt_abs_sine) ? (phase_inc << 1) : phase_inc;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_acc <= '0;
        end else if (en) begin
            phase_acc <= phase_acc + step; // Wraps naturally.
        end
    end

    sine_lut sine_lut_i (
        .clk     (clk),
        .theta   (phase_acc[PHASE_ACC_WIDTH-1 -: LUT_INPUT_WIDTH]),
        .lut_out (lut_out)
    );

    // Positive to negative crossing marks a new period.
    assign sign_wrap = lut_out[OUTPUT_WIDTH-1] && !sign_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            sign_q   <= 1'b0;
            is_odd_q <= 1'b0;
        end else begin
            sign_q <= lut_out[OUTPUT_WIDTH-1];
            if (sign_wrap) begin
                is_odd_q <= !is_odd_q;
            end
        end
    end

    // Sample that shows the wrap already counts in the new period.
    assign odd_period = is_odd_q ^ sign_wrap;

    assign abs_sine = lut_out[OUTPUT_WIDTH-1] ? ~lut_out : lut_out; // One's complement.
    assign alt_sine = odd_period ? lut_out : '0;

    always_comb begin
        case (ws)
            ws_sine:         shaped = lut_out;
            ws_half_sine:    shaped = lut_out[OUTPUT_WIDTH-1] ? '0 : lut_out;
            ws_abs_sine:     shaped = abs_sine;
            ws_pulse_sine:   shaped = phase_acc[PHASE_ACC_WIDTH-2] ? '0 : abs_sine;
            ws_alt_sine:     shaped = alt_sine;
            ws_alt_abs_sine: shaped = alt_sine[OUTPUT_WIDTH-1] ? ~alt_sine : alt_sine;
            ws_square:       shaped = (lut_out > 0) ? FULL_POS : FULL_NEG;
            default:         shaped = lut_out; // Reserved code repeats the sine.
        endcase
    end

    // Enable follows the sample through accumulator and table.
    always_ff @(posedge clk) begin
        if (rst) begin
            en_q1 <= 1'b0;
            en_q2 <= 1'b0;
        end else begin
            en_q1 <= en;
            en_q2 <= en_q1;
        end
    end

    // One-deep output register.
    // The strobe holds off while full, so a capture never lands on a held sample.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (en_q2) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0; // Taken by the sink.
        end
    end

    always_ff @(posedge clk) begin
        if (en_q2) begin
            out <= shaped;
        end
    end

    assign stall = out_valid && !out_ready;

endmodule

//--- hw/opl3_osc_regs.sv
// Oscillator register block.
// Takes host writes and holds the phase increment and waveform select.
`timescale 1ns/1ps

module opl3_osc_regs
    import opl3_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wr_valid,
    output logic                       wr_ready,
    input  logic [REG_ADDR_WIDTH-1:0]  wr_addr,
    input  logic [WR_DATA_WIDTH-1:0]   wr_data,
    output logic [PHASE_ACC_WIDTH-1:0] phase_inc,
    output waveform_t                  ws
);

    localparam int HI_WIDTH = PHASE_ACC_WIDTH - WR_DATA_WIDTH; // Upper increment bits.

    logic wr_fire;

    // Port is always free except while in reset.
    assign wr_ready = !rst;
    assign wr_fire  = wr_valid && wr_ready;

    // Each half lands as soon as it is written.
    // A two-write update may glitch for a cycle or two.
    always_ff @(posedge clk) begin
        if (rst) begin
            phase_inc <= '0;
            ws        <= ws_sine;
        end else if (wr_fire) begin
            case (wr_addr)
                ADDR_PHASE_INC_LO: begin
                    phase_inc[WR_DATA_WIDTH-1:0] <= wr_data; // Low 16 bits.
                end
                ADDR_PHASE_INC_HI: begin
                    phase_inc[PHASE_ACC_WIDTH-1:WR_DATA_WIDTH] <= wr_data[HI_WIDTH-1:0];
                end
                ADDR_WS: begin
                    ws <= waveform_t'(wr_data[REG_WS_WIDTH-1:0]); // All eight codes legal.
                end
                default: begin
                    // Unmapped address, write is dropped.
                end
            endcase
        end
    end

endmodule

//--- hw/opl3_osc_top.sv
// OPL3 oscillator channel top.
// Register block, sample strobe and NCO with its sine table.
`timescale 1ns/1ps

module opl3_osc_top
    import opl3_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_valid,
    output logic                           wr_ready,
    input  logic [REG_ADDR_WIDTH-1:0]      wr_addr,
    input  logic [WR_DATA_WIDTH-1:0]       wr_data,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic signed [OUTPUT_WIDTH-1:0] out
);

    logic [PHASE_ACC_WIDTH-1:0] phase_inc;
    waveform_t                  ws;
    logic                       en;     // One pulse per sample.
    logic                       stall;  // Output held by the sink.

    opl3_osc_regs opl3_osc_regs_i (
        .clk       (clk),
        .rst       (rst),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .phase_inc (phase_inc),
        .ws        (ws)
    );

    sample_strobe sample_strobe_i (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .en    (en)
    );

    nco nco_i (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .phase_inc (phase_inc),
        .ws        (ws),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out),
        .stall     (stall)
    );

endmodule

//--- hw/opl3_pkg.sv
// OPL3 oscillator channel package.
// Widths, register map, sample pacing and the waveform select encoding.
package opl3_pkg;

    localparam int PHASE_ACC_WIDTH = 20; // Accumulator and increment width.
    localparam int LUT_INPUT_WIDTH = 10; // Upper phase bits into the sine table.
    localparam int LUT_QUARTER_DEPTH = 2 ** (LUT_INPUT_WIDTH - 2); // Stored quarter wave.
    localparam int OUTPUT_WIDTH = 14;    // Signed sample width.
    localparam int REG_WS_WIDTH = 3;     // Waveform select width.

    // Clocks per audio sample.
    localparam int SAMPLE_DIV = 8;
    localparam int SAMPLE_CNT_WIDTH = $clog2(SAMPLE_DIV);

    // Host write port.
    localparam int REG_ADDR_WIDTH = 2;
    localparam int WR_DATA_WIDTH = 16;

    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_PHASE_INC_LO = 2'd0; // Increment bits 15:0.
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_PHASE_INC_HI = 2'd1; // Increment bits 19:16.
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_WS = 2'd2;           // Waveform select.

    // Used to build the sine table at elaboration.
    localparam real PI = 3.14159265358979323846;

    // OPL3 waveform select.
    typedef enum logic [REG_WS_WIDTH-1:0] {
        ws_sine         = 3'd0,
        ws_half_sine    = 3'd1,
        ws_abs_sine     = 3'd2,
        ws_pulse_sine   = 3'd3,
        ws_alt_sine     = 3'd4, // Double rate, odd periods only.
        ws_alt_abs_sine = 3'd5,
        ws_square       = 3'd6,
        ws_sine_rsvd    = 3'd7  // Same as plain sine.
    } waveform_t;

endpackage

//--- hw/sample_strobe.sv
// Sample strobe.
// One enable pulse per sample period, paused while the output is stalled.
`timescale 1ns/1ps

module sample_strobe
    import opl3_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic stall,
    output logic en
);

    logic [SAMPLE_CNT_WIDTH-1:0] cnt;
    logic                        terminal;

    assign terminal = (cnt == SAMPLE_CNT_WIDTH'(SAMPLE_DIV - 1));

    // No pulse while the output register is blocked.
    assign en = terminal && !stall;

    // Counter freezes under stall so the pace stretches.
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (!stall) begin
            if (terminal) begin
                cnt <= '0; // Wrap at end of period.
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

//--- hw/sine_lut.sv
// Sine lookup.
// Quarter-wave table unfolded to a full signed period, registered output.
`timescale 1ns/1ps

module sine_lut
    import opl3_pkg::*;
(
    input  logic                           clk,
    input  logic [LUT_INPUT_WIDTH-1:0]     theta,
    output logic signed [OUTPUT_WIDTH-1:0] lut_out
);

    localparam int IDX_WIDTH = LUT_INPUT_WIDTH - 2;
    localparam int MAG_WIDTH = OUTPUT_WIDTH - 1;

    logic [MAG_WIDTH-1:0] rom [LUT_QUARTER_DEPTH];
    logic [IDX_WIDTH-1:0] idx;
    logic [MAG_WIDTH-1:0] mag;
    logic signed [OUTPUT_WIDTH-1:0] mag_s;

    // Entry k is sin at the middle of step k, scaled to full positive range.
    // Taylor series, plenty of terms for x below pi/2.
    function automatic logic [MAG_WIDTH-1:0] quarter_entry(input int k);
        real x;
        real term;
        real sum;
        int  scaled;
        x    = 2.0 * PI * (real'(k) + 0.5) / real'(2 ** LUT_INPUT_WIDTH);
        term = x;
        sum  = x;
        for (int n = 1; n < 14; n++) begin
            term = -term * x * x / real'((2 * n) * (2 * n + 1));
            sum  = sum + term;
        end
        scaled = int'(sum * real'(2 ** MAG_WIDTH - 1)); // Rounds to nearest.
        return scaled[MAG_WIDTH-1:0];
    endfunction

    initial begin
        for (int i = 0; i < LUT_QUARTER_DEPTH; i++) begin
            rom[i] = quarter_entry(i);
        end
    end

    // Second and fourth quarters read the table backwards.
    // The half-step offset makes the mirror exact.
    assign idx = theta[LUT_INPUT_WIDTH-2] ? ~theta[IDX_WIDTH-1:0] : theta[IDX_WIDTH-1:0];
    assign mag = rom[idx];
    assign mag_s = signed'({1'b0, mag}); // Always positive.

    // Second half of the period is negative.
    always_ff @(posedge clk) begin
        if (theta[LUT_INPUT_WIDTH-1]) begin
            lut_out <= -mag_s;
        end else begin
            lut_out <= mag_s;
        end
    end

endmodule

//--- verification/opl3_osc_tb.sv
// OPL3 oscillator channel testbench.
// Drives the register port, models phase and shape, checks every accepted sample.
`timescale 1ns/1ps

module opl3_osc_tb
    import opl3_pkg::*;
;

    localparam int FULL_POS = 2 ** (OUTPUT_WIDTH - 1) - 1;
    localparam int FULL_NEG = -(2 ** (OUTPUT_WIDTH - 1));
    localparam int QUARTER = 2 ** (LUT_INPUT_WIDTH - 2); // Entries per quarter wave.
    localparam real TWO_PI = 6.28318530717958647692;
    localparam logic [REG_ADDR_WIDTH-1:0] UNMAPPED_ADDR = 2'd3;

    localparam logic [PHASE_ACC_WIDTH-1:0] INC_A = 20'h0_9A3D; // About 27 samples a period.
    localparam logic [PHASE_ACC_WIDTH-1:0] INC_B = 20'h1_3579; // Needs the high half.

    // Samples per section.
    localparam int N_CONFIG = 11;  // One held sample per reconfiguration.
    localparam int N_SINE = 24;
    localparam int N_RSVD = 12;
    localparam int N_SHAPE = 16;
    localparam int N_ALT = 32;
    localparam int N_BP = 40;
    localparam int N_UNMAPPED = 16;
    localparam int N_NEW_INC = 24;
    localparam int TOTAL_SAMPLES = N_CONFIG + N_SINE + N_RSVD + 4 * N_SHAPE + 2 * N_ALT
                                   + N_BP + N_UNMAPPED + N_NEW_INC;
    localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * SAMPLE_DIV * 4;

    logic                           clk;
    logic                           rst;
    logic                           wr_valid;
    logic                           wr_ready;
    logic [REG_ADDR_WIDTH-1:0]      wr_addr;
    logic [WR_DATA_WIDTH-1:0]       wr_data;
    logic                           out_valid;
    logic                           out_ready;
    logic signed [OUTPUT_WIDTH-1:0] out;

    // Reference model state.
    logic [PHASE_ACC_WIDTH-1:0] m_acc;
    logic [PHASE_ACC_WIDTH-1:0] m_inc;
    waveform_t                  m_ws;
    bit                         m_prev_neg;  // Sign of the last sample's sine.
    int                         m_periods;   // Sign wraps seen so far.

    integer seed;
    logic   held = 1'b0;
    logic signed [OUTPUT_WIDTH-1:0] held_out;

    tb_clk_gen tb_clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    opl3_osc_top opl3_osc_top_i (
        .clk       (clk),
        .rst       (rst),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

    task automatic report_failure();
        $display("Errors found");
        $fatal(1, "Stopped at the first failing check.");
    endtask

    // Quarter entry k is sin at the middle of step k.
    function automatic int sine_value(input logic [LUT_INPUT_WIDTH-1:0] theta);
        int  k;
        int  mag;
        real x;
        k = theta[LUT_INPUT_WIDTH-3:0];
        if (theta[LUT_INPUT_WIDTH-2]) begin
            k = QUARTER - 1 - k; // Falling quarters read backwards.
        end
        x = TWO_PI * (real'(k) + 0.5) / real'(2 ** LUT_INPUT_WIDTH);
        mag = int'(real'(FULL_POS) * $sin(x));
        return theta[LUT_INPUT_WIDTH-1] ? -mag : mag; // Second half negative.
    endfunction

    function automatic int shape(input waveform_t wave, input int s, input bit odd,
                                 input bit quarter_off);
        int mag;
        mag = (s < 0) ? -s - 1 : s; // One's complement of a negative value.
        case (wave)
            ws_half_sine:    return (s < 0) ? 0 : s;
            ws_abs_sine:     return mag;
            ws_pulse_sine:   return quarter_off ? 0 : mag;
            ws_alt_sine:     return odd ? s : 0;
            ws_alt_abs_sine: return odd ? mag : 0;
            ws_square:       return (s > 0) ? FULL_POS : FULL_NEG;
            default:         return s;
        endcase
    endfunction

    // Advance phase, track periods and shape one accepted sample.
    task automatic model_step(output int expected);
        logic [PHASE_ACC_WIDTH-1:0] step;
        int s;
        bit neg;
        step = m_inc;
        if (m_ws == ws_alt_sine || m_ws == ws_alt_abs_sine) begin
            step = PHASE_ACC_WIDTH'(2 * m_inc); // Double pitch.
        end
        m_acc = m_acc + step;
        s = sine_value(m_acc[PHASE_ACC_WIDTH-1 -: LUT_INPUT_WIDTH]);
        neg = (s < 0);
        if (neg && !m_prev_neg) begin
            m_periods++; // Positive to negative wrap.
        end
        m_prev_neg = neg;
        expected = shape(m_ws, s, m_periods[0], m_acc[PHASE_ACC_WIDTH-2]);
    endtask

    task automatic write_reg(input logic [REG_ADDR_WIDTH-1:0] addr,
                             input logic [WR_DATA_WIDTH-1:0] data);
        wr_valid <= 1'b1;
        wr_addr  <= addr;
        wr_data  <= data;
        @(posedge clk);
        assert (wr_ready === 1'b1) else begin
            $display("FAIL t=%0t wr_ready: expected 1, actual %b", $time, wr_ready);
            report_failure();
        end
        wr_valid <= 1'b0;
    endtask

    // Accept n samples, checking each against the model.
    task automatic take_samples(input int n, input bit random_ready);
        int taken;
        int expected;
        int rnd;
        taken = 0;
        while (taken < n) begin
            @(posedge clk);
            if (out_valid === 1'b1 && out_ready === 1'b1) begin
                model_step(expected);
                assert (int'(out) == expected) else begin
                    $display("FAIL t=%0t out: expected %0d, actual %0d", $time, expected, out);
                    report_failure();
                end
                taken++;
            end
            rnd = $random(seed);
            out_ready <= random_ready ? rnd[0] : 1'b1;
        end
    endtask

    // Park a finished sample in the output register; the strobe then stays frozen.
    task automatic hold_output();
        out_ready <= 1'b0;
        do begin
            @(posedge clk);
        end while (out_valid !== 1'b1);
    endtask

    task automatic configure(input logic [PHASE_ACC_WIDTH-1:0] inc, input waveform_t wave);
        hold_output();
        write_reg(ADDR_PHASE_INC_LO, inc[WR_DATA_WIDTH-1:0]);
        write_reg(ADDR_PHASE_INC_HI, WR_DATA_WIDTH'(inc[PHASE_ACC_WIDTH-1:WR_DATA_WIDTH]));
        write_reg(ADDR_WS, WR_DATA_WIDTH'(wave));
        take_samples(1, 1'b0); // Held sample was made with the old setting.
        m_inc = inc;
        m_ws  = wave;
    endtask

    // Output stays empty while reset is applied.
    always @(negedge clk) begin
        if (rst === 1'b1 && $time > 0) begin
            assert (out_valid === 1'b0) else begin
                $display("FAIL t=%0t out_valid: expected 0, actual %b", $time, out_valid);
                report_failure();
            end
        end
    end

    // A held sample must still be there, unchanged, one cycle later.
    always @(posedge clk) begin
        if (held) begin
            assert (out_valid === 1'b1 && out === held_out) else begin
                $display("FAIL t=%0t out: expected %0d (held), actual %0d, out_valid %b",
                         $time, held_out, out, out_valid);
                report_failure();
            end
        end
        held = (rst === 1'b0) && (out_valid === 1'b1) && (out_ready === 1'b0);
        held_out = out;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run timed out before all samples were taken.");
        report_failure();
    end

    initial begin
        wr_valid   = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        out_ready  = 1'b0;
        seed       = 60;
        m_acc      = '0;
        m_inc      = '0;   // Registers clear at reset.
        m_ws       = ws_sine;
        m_prev_neg = 1'b0;
        m_periods  = 0;

        @(posedge clk);
        while (rst) @(posedge clk);
        // First edge out of reset.
        assert (out_valid === 1'b0) else begin
            $display("FAIL t=%0t out_valid: expected 0, actual %b", $time, out_valid);
            report_failure();
        end
        assert (wr_ready === 1'b1) else begin
            $display("FAIL t=%0t wr_ready: expected 1, actual %b", $time, wr_ready);
            report_failure();
        end

        configure(INC_A, ws_sine);
        take_samples(N_SINE, 1'b0);
        configure(INC_A, ws_sine_rsvd);
        take_samples(N_RSVD, 1'b0);

        configure(INC_A, ws_half_sine);
        take_samples(N_SHAPE, 1'b0);
        configure(INC_A, ws_abs_sine);
        take_samples(N_SHAPE, 1'b0);
        configure(INC_A, ws_pulse_sine);
        take_samples(N_SHAPE, 1'b0);
        configure(INC_A, ws_square);
        take_samples(N_SHAPE, 1'b0);

        // Alternating shapes span a few periods each.
        configure(INC_A, ws_alt_sine);
        take_samples(N_ALT, 1'b0);
        configure(INC_A, ws_alt_abs_sine);
        take_samples(N_ALT, 1'b0);

        // Random sink readiness.
        configure(INC_A, ws_abs_sine);
        take_samples(N_BP, 1'b1);

        // Unmapped write must not disturb anything.
        hold_output();
        write_reg(UNMAPPED_ADDR, 16'hFFFF);
        take_samples(1, 1'b0);
        take_samples(N_UNMAPPED, 1'b1);

        // New increment between two samples.
        configure(INC_B, ws_sine);
        take_samples(N_NEW_INC, 1'b1);

        $display("No errors");
        $finish;
    end

endmodule

//--- verification/tb_clk_gen.sv
// Testbench clock and reset.
// 20 ns clock, reset held high for the first five rising edges.
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0; // Released on a rising edge like every other input.
    end

endmodule
